/* xm_pkg.sv */
////////////////////////////////////////////////////////////
// shared types and constants for the video host register block
// register numbers, bus/VRAM widths, timer divisor and the
// bus event and VRAM request structs used between modules
////////////////////////////////////////////////////////////

package xm_pkg;

    localparam int BYTE_W = 8;                  // cpu bus byte
    localparam int WORD_W = 16;                 // register and VRAM word
    localparam int MASK_W = 4;                  // one bit per nibble of a word

    // clocks per timer tick minus one
    // short value for simulation, hardware derives it from the pixel clock
    localparam int TIMER_DIV    = 15;
    localparam int TIMER_FRAC_W = $clog2(TIMER_DIV + 1);   // width of tick fraction counter

    // register numbers, also used as the bus opcode
    typedef enum logic [3:0] {
        XR_ADDR   = 4'h0,               // dropped, reads zero
        XR_DATA   = 4'h1,               // dropped
        RD_INCR   = 4'h2,
        RD_ADDR   = 4'h3,               // odd write starts a read
        WR_INCR   = 4'h4,
        WR_ADDR   = 4'h5,
        DATA      = 4'h6,               // VRAM data port
        DATA_2    = 4'h7,               // alias of DATA
        SYS_CTRL  = 4'h8,               // nibble write mask
        TIMER     = 4'h9,               // 1/10 ms count
        UNUSED_A  = 4'hA,
        UNUSED_B  = 4'hB,
        RW_INCR   = 4'hC,               // dropped rw port
        RW_ADDR   = 4'hD,
        RW_DATA   = 4'hE,
        RW_DATA_2 = 4'hF
    } xm_reg_e;

    // registered bus activity, one cycle after the bus strobe
    typedef struct packed {
        logic                 even_wr;      // even byte written
        logic                 word_wr;      // odd byte written, word complete
        logic                 word_rd;      // odd byte read
        xm_reg_e              reg_num;      // register addressed
        logic [BYTE_W-1:0]    data_byte;    // raw bus byte
        logic [WORD_W-1:0]    word;         // paired even/odd word
    } xm_bus_evt_t;

    // VRAM access request, held until vgen_sel_i is low
    typedef struct packed {
        logic                 sel;          // VRAM select
        logic                 wr;           // write, else read
        logic [MASK_W-1:0]    wrmask;       // nibble write enables
        logic [WORD_W-1:0]    addr;         // word address
        logic [WORD_W-1:0]    data;         // write data
    } xm_vram_req_t;

endpackage

/* xm_byte_pair.sv */
////////////////////////////////////////////////////////////
// pairs the even and odd bytes of the 8-bit cpu bus into
// 16-bit register words; every bus strobe comes out one
// cycle later as a pulse in the bus event struct
////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module xm_byte_pair (
    input  logic                        clk,
    input  logic                        reset_i,
    input  logic                        bus_wr_i,       // one cycle write strobe
    input  logic                        bus_rd_i,       // one cycle read strobe
    input  xm_pkg::xm_reg_e             bus_reg_num_i,  // register number
    input  logic                        bus_bytesel_i,  // 0 = even = high byte
    input  logic [xm_pkg::BYTE_W-1:0]   bus_data_i,     // bus write byte
    output xm_pkg::xm_bus_evt_t         evt_o           // registered bus event
);
    import xm_pkg::*;

    logic [BYTE_W-1:0]  data_even;      // even byte latch for DATA/DATA_2
    logic [BYTE_W-1:0]  other_even;     // generic even byte latch
    xm_reg_e            other_reg;      // owner of other_even
    logic [BYTE_W-1:0]  even_byte;      // high byte used on odd write
    logic               is_data;        // bus addresses DATA or DATA_2
    logic               is_addr;        // address regs keep their own high byte

    assign is_data = (bus_reg_num_i == DATA) || (bus_reg_num_i == DATA_2);
    assign is_addr = (bus_reg_num_i == RD_ADDR) || (bus_reg_num_i == WR_ADDR);

    // pick the high byte for the word being completed
    always_comb begin
        if (is_data) begin
            even_byte = data_even;
        end else if (other_reg == bus_reg_num_i) begin
            even_byte = other_even;
        end else begin
            even_byte = '0;                         // even byte went elsewhere
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            data_even  <= '0;
            other_even <= '0;
            other_reg  <= XR_ADDR;
            evt_o      <= '0;
        end else begin
            evt_o.even_wr   <= bus_wr_i && !bus_bytesel_i;
            evt_o.word_wr   <= bus_wr_i && bus_bytesel_i;
            evt_o.word_rd   <= bus_rd_i && bus_bytesel_i;   // only odd reads matter
            evt_o.reg_num   <= bus_reg_num_i;
            evt_o.data_byte <= bus_data_i;
            evt_o.word      <= {even_byte, bus_data_i};

            if (bus_wr_i && !bus_bytesel_i) begin
                if (is_data) begin
                    data_even <= bus_data_i;            // held until odd byte
                end else if (!is_addr) begin
                    other_even <= bus_data_i;           // tagged with its register
                    other_reg  <= bus_reg_num_i;
                end
            end
        end
    end

endmodule

/* xm_vram_port.sv */
////////////////////////////////////////////////////////////
// cpu side VRAM port: read and write address/increment regs,
// request issue with hold against the video generator, and
// capture of read data with prefetch on DATA reads
////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module xm_vram_port (
    input  logic                        clk,
    input  logic                        reset_i,
    input  xm_pkg::xm_bus_evt_t         evt_i,          // paired bus event
    input  logic [xm_pkg::MASK_W-1:0]   wrmask_i,       // SYS_CTRL nibble mask
    input  logic                        vgen_sel_i,     // video owns VRAM this cycle
    input  logic [xm_pkg::WORD_W-1:0]   vram_data_i,    // VRAM read data
    output xm_pkg::xm_vram_req_t        req_o,          // VRAM request
    output logic [xm_pkg::WORD_W-1:0]   rd_addr_o,      // for readback
    output logic [xm_pkg::WORD_W-1:0]   rd_incr_o,
    output logic [xm_pkg::WORD_W-1:0]   wr_addr_o,
    output logic [xm_pkg::WORD_W-1:0]   wr_incr_o,
    output logic [xm_pkg::WORD_W-1:0]   rd_word_o       // last word read
);
    import xm_pkg::*;

    logic   rd_pend;        // read request outstanding
    logic   rd_ack;         // read accepted last cycle, data on bus now
    logic   accept;         // request taken this cycle
    logic   is_data;        // event addresses DATA or DATA_2

    assign accept  = req_o.sel && !vgen_sel_i;
    assign is_data = (evt_i.reg_num == DATA) || (evt_i.reg_num == DATA_2);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            req_o.sel    <= 1'b0;
            req_o.wr     <= 1'b0;
            req_o.wrmask <= '1;
            req_o.addr   <= '0;
            req_o.data   <= '0;
            rd_pend      <= 1'b0;
            rd_ack       <= 1'b0;
            rd_addr_o    <= '0;
            rd_incr_o    <= '0;
            wr_addr_o    <= '0;
            wr_incr_o    <= '0;
            rd_word_o    <= '0;             // DATA reads zero after reset
        end else begin
            // capture read word the cycle after the ack
            if (rd_ack) begin
                rd_word_o <= vram_data_i;
            end
            rd_ack <= 1'b0;

            // video slot free, pending request completes now
            if (!vgen_sel_i) begin
                rd_ack <= rd_pend;
                if (rd_pend) begin
                    rd_addr_o <= rd_addr_o + rd_incr_o;     // step to next read word
                end
                if (accept && req_o.wr) begin
                    wr_addr_o <= wr_addr_o + wr_incr_o;     // auto-increment after write
                end
                req_o.sel <= 1'b0;
                req_o.wr  <= 1'b0;
                rd_pend   <= 1'b0;
            end

            // even byte of an address goes straight into the high half
            if (evt_i.even_wr) begin
                case (evt_i.reg_num)
                    RD_ADDR: rd_addr_o[WORD_W-1:BYTE_W] <= evt_i.data_byte;
                    WR_ADDR: wr_addr_o[WORD_W-1:BYTE_W] <= evt_i.data_byte;
                    default: ;
                endcase
            end

            // odd byte completes the word, may start a request
            if (evt_i.word_wr) begin
                case (evt_i.reg_num)
                    RD_INCR: begin
                        rd_incr_o <= evt_i.word;
                    end
                    RD_ADDR: begin
                        rd_addr_o[BYTE_W-1:0] <= evt_i.word[BYTE_W-1:0];
                        req_o.addr   <= {rd_addr_o[WORD_W-1:BYTE_W], evt_i.word[BYTE_W-1:0]};
                        req_o.sel    <= 1'b1;           // read at new address
                        req_o.wr     <= 1'b0;
                        req_o.wrmask <= wrmask_i;
                        rd_pend      <= 1'b1;
                    end
                    WR_INCR: begin
                        wr_incr_o <= evt_i.word;
                    end
                    WR_ADDR: begin
                        wr_addr_o[BYTE_W-1:0] <= evt_i.word[BYTE_W-1:0];
                    end
                    DATA, DATA_2: begin
                        req_o.addr   <= wr_addr_o;      // write at current wr address
                        req_o.data   <= evt_i.word;
                        req_o.sel    <= 1'b1;
                        req_o.wr     <= 1'b1;
                        req_o.wrmask <= wrmask_i;
                        rd_pend      <= 1'b0;           // replaces any held read
                    end
                    default: ;                          // other regs handled elsewhere
                endcase
            end

            // odd DATA read prefetches the word at rd address
            if (evt_i.word_rd && is_data) begin
                req_o.addr   <= rd_addr_o;
                req_o.sel    <= 1'b1;
                req_o.wr     <= 1'b0;
                req_o.wrmask <= wrmask_i;
                rd_pend      <= 1'b1;
            end
        end
    end

endmodule

/* xm_tick_timer.sv */
////////////////////////////////////////////////////////////
// free-running 1/10 ms timer; a fraction counter divides
// the clock by TIMER_DIV+1 and steps a wrapping 16-bit count
////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module xm_tick_timer (
    input  logic                        clk,
    input  logic                        reset_i,
    output logic [xm_pkg::WORD_W-1:0]   count_o     // ticks since reset
);
    import xm_pkg::*;

    logic [TIMER_FRAC_W-1:0] frac;      // clocks within current tick

    always_ff @(posedge clk) begin
        if (reset_i) begin
            frac    <= '0;
            count_o <= '0;
        end else if (frac == TIMER_FRAC_W'(TIMER_DIV)) begin
            frac    <= '0;
            count_o <= count_o + 1'b1;  // wraps at 16 bits
        end else begin
            frac    <= frac + 1'b1;
        end
    end

endmodule

/* xm_regs_top.sv */
////////////////////////////////////////////////////////////
// host register block top: bus byte pairing, VRAM port,
// timer and the SYS_CTRL write mask, plus the combinational
// byte readback of the register on the bus
////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module xm_regs_top (
    input  logic                        clk,
    input  logic                        reset_i,
    input  logic                        bus_wr_i,       // synchronized write strobe
    input  logic                        bus_rd_i,       // synchronized read strobe
    input  xm_pkg::xm_reg_e             bus_reg_num_i,
    input  logic                        bus_bytesel_i,  // 0 = even = high byte
    input  logic [xm_pkg::BYTE_W-1:0]   bus_data_i,
    output logic [xm_pkg::BYTE_W-1:0]   bus_data_o,     // readback byte
    input  logic                        vgen_sel_i,     // video generator owns VRAM
    output xm_pkg::xm_vram_req_t        vram_req_o,
    input  logic [xm_pkg::WORD_W-1:0]   vram_data_i
);
    import xm_pkg::*;

    xm_bus_evt_t        evt;            // paired bus event
    logic [MASK_W-1:0]  wrmask;         // SYS_CTRL nibble mask
    logic [WORD_W-1:0]  rd_addr;
    logic [WORD_W-1:0]  rd_incr;
    logic [WORD_W-1:0]  wr_addr;
    logic [WORD_W-1:0]  wr_incr;
    logic [WORD_W-1:0]  rd_word;        // last VRAM read word
    logic [WORD_W-1:0]  timer_count;
    logic [WORD_W-1:0]  rb_word;        // word of the addressed register

    xm_byte_pair u_xm_byte_pair (
        .clk           (clk),
        .reset_i       (reset_i),
        .bus_wr_i      (bus_wr_i),
        .bus_rd_i      (bus_rd_i),
        .bus_reg_num_i (bus_reg_num_i),
        .bus_bytesel_i (bus_bytesel_i),
        .bus_data_i    (bus_data_i),
        .evt_o         (evt)
    );

    xm_vram_port u_xm_vram_port (
        .clk         (clk),
        .reset_i     (reset_i),
        .evt_i       (evt),
        .wrmask_i    (wrmask),
        .vgen_sel_i  (vgen_sel_i),
        .vram_data_i (vram_data_i),
        .req_o       (vram_req_o),
        .rd_addr_o   (rd_addr),
        .rd_incr_o   (rd_incr),
        .wr_addr_o   (wr_addr),
        .wr_incr_o   (wr_incr),
        .rd_word_o   (rd_word)
    );

    xm_tick_timer u_xm_tick_timer (
        .clk     (clk),
        .reset_i (reset_i),
        .count_o (timer_count)
    );

    // mask taken from high nibble of the even byte; odd byte ignored
    always_ff @(posedge clk) begin
        if (reset_i) begin
            wrmask <= '1;                   // all nibbles writable
        end else if (evt.word_wr && (evt.reg_num == SYS_CTRL)) begin
            wrmask <= evt.word[WORD_W-MASK_W +: MASK_W];
        end
    end

    // readback word select, dropped regs read zero
    always_comb begin
        case (bus_reg_num_i)
            RD_INCR:      rb_word = rd_incr;
            RD_ADDR:      rb_word = rd_addr;
            WR_INCR:      rb_word = wr_incr;
            WR_ADDR:      rb_word = wr_addr;
            DATA, DATA_2: rb_word = rd_word;
            SYS_CTRL:     rb_word = {{(BYTE_W - MASK_W){1'b0}}, wrmask, {BYTE_W{1'b0}}};
            TIMER:        rb_word = timer_count;
            default:      rb_word = '0;
        endcase
    end

    assign bus_data_o = bus_bytesel_i ? rb_word[BYTE_W-1:0] : rb_word[WORD_W-1:BYTE_W];

endmodule

/* xm_regs_asserts.sv */
////////////////////////////////////////////////////////////
// concurrent checks on the VRAM request handshake,
// bound into every xm_vram_port instance
////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module xm_regs_asserts (
    input  logic                    clk,
    input  logic                    reset_i,
    input  logic                    vgen_sel_i,     // video owns VRAM
    input  xm_pkg::xm_vram_req_t    req_o           // request under check
);

    // a write is always a selected access
    wr_needs_sel: assert property (
        @(posedge clk) disable iff (reset_i) req_o.wr |-> req_o.sel
    ) else $error("VRAM wr high without sel");

    // blocked request holds still
    held_req_stable: assert property (
        @(posedge clk) disable iff (reset_i)
        (req_o.sel && vgen_sel_i) |=>
            (req_o.sel && $stable(req_o.addr) && $stable(req_o.data))
    ) else $error("held VRAM request changed while blocked");

    // no request leaves reset
    sel_low_after_reset: assert property (
        @(posedge clk) reset_i |=> !req_o.sel
    ) else $error("VRAM sel high after reset");

endmodule

bind xm_vram_port xm_regs_asserts u_xm_regs_asserts (
    .clk        (clk),
    .reset_i    (reset_i),
    .vgen_sel_i (vgen_sel_i),
    .req_o      (req_o)
);

/* tb_xm_regs.sv */
////////////////////////////////////////////////////////////
// directed testbench for the video host register block
// drives the byte bus, models VRAM and checks readback,
// VRAM access, write mask, arbitration and the timer
////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module tb_xm_regs;
    import xm_pkg::*;

    localparam int CLK_HALF    = 20;            // 40 ns period
    localparam int ACC_LIMIT   = 200;           // cycles to wait for one acceptance
    localparam int TEST_CYCLES = 3000;          // summed length of all tests, in clocks

    logic               clk = 1'b0;
    logic               reset_i;
    logic               bus_wr_i;
    logic               bus_rd_i;
    xm_reg_e            bus_reg_num_i;
    logic               bus_bytesel_i;
    logic [BYTE_W-1:0]  bus_data_i;
    logic [BYTE_W-1:0]  bus_data_o;
    logic               vgen_sel_i;
    xm_vram_req_t       vram_req_o;
    logic [WORD_W-1:0]  vram_data_i;

    logic [WORD_W-1:0]  vram_mem [0:65535];     // behavioural VRAM
    xm_vram_req_t       last_req;               // request seen at last acceptance
    logic [31:0]        lfsr_state = 32'h12dd;
    logic [31:0]        vgen_lfsr = 32'h12dd;   // own stream for the video slots
    int                 accept_cnt = 0;
    int                 err_cnt = 0;
    int                 tests_run = 0;
    int                 tests_failed = 0;
    logic               arb_on = 1'b0;          // video generator contends for VRAM

    xm_regs_top u_xm_regs_top (
        .clk           (clk),
        .reset_i       (reset_i),
        .bus_wr_i      (bus_wr_i),
        .bus_rd_i      (bus_rd_i),
        .bus_reg_num_i (bus_reg_num_i),
        .bus_bytesel_i (bus_bytesel_i),
        .bus_data_i    (bus_data_i),
        .bus_data_o    (bus_data_o),
        .vgen_sel_i    (vgen_sel_i),
        .vram_req_o    (vram_req_o),
        .vram_data_i   (vram_data_i)
    );

    always #CLK_HALF clk = ~clk;

    // galois lfsr, one step per bit
    function automatic logic lfsr_bit(inout logic [31:0] state);
        logic b;
        b = state[0];
        state = (state >> 1) ^ (b ? 32'h8020_0003 : 32'h0);
        return b;
    endfunction

    function automatic logic [WORD_W-1:0] rand_word(input int nbits);
        logic [WORD_W-1:0] w;
        w = '0;
        for (int i = 0; i < nbits; i++) begin
            w = {w[WORD_W-2:0], lfsr_bit(lfsr_state)};
        end
        return w;
    endfunction

    // old word with the enabled nibbles replaced
    function automatic logic [WORD_W-1:0] mask_merge(input logic [WORD_W-1:0] old_w,
                                                     input logic [WORD_W-1:0] new_w,
                                                     input logic [MASK_W-1:0] mask);
        logic [WORD_W-1:0] res;
        res = old_w;
        for (int i = 0; i < MASK_W; i++) begin
            if (mask[i]) res[4*i +: 4] = new_w[4*i +: 4];
        end
        return res;
    endfunction

    function automatic logic [WORD_W-1:0] fill_pattern(input logic [WORD_W-1:0] a);
        return (a * 16'h9e37) ^ 16'hc3a5;       // odd multiplier, every address bit counts
    endfunction

    function automatic xm_vram_req_t make_wr_req(input logic [MASK_W-1:0] mask,
                                                 input logic [WORD_W-1:0] addr,
                                                 input logic [WORD_W-1:0] data);
        xm_vram_req_t r;
        r.sel    = 1'b1;
        r.wr     = 1'b1;
        r.wrmask = mask;
        r.addr   = addr;
        r.data   = data;
        return r;
    endfunction

    // request fields as text for error lines
    function automatic string req_text(input xm_vram_req_t r);
        return $sformatf("sel %b wr %b mask %h addr %h data %h",
                         r.sel, r.wr, r.wrmask, r.addr, r.data);
    endfunction

    always @(posedge clk) begin
        vgen_sel_i <= arb_on ? lfsr_bit(vgen_lfsr) : 1'b0;   // half the cycles owned by video
    end

    // VRAM model, acts on acceptance
    always @(posedge clk) begin
        if (!reset_i && vram_req_o.sel && !vgen_sel_i) begin
            accept_cnt <= accept_cnt + 1;
            last_req   <= vram_req_o;
            if (vram_req_o.wr) begin
                vram_mem[vram_req_o.addr] <= mask_merge(vram_mem[vram_req_o.addr],
                                                        vram_req_o.data, vram_req_o.wrmask);
            end else begin
                vram_data_i <= vram_mem[vram_req_o.addr];   // valid the cycle after
            end
        end
    end

    task automatic check_word(input string name, input logic [WORD_W-1:0] exp,
                              input logic [WORD_W-1:0] act);
        if (act !== exp) begin
            $display("FAIL %0t %s expected %h actual %h", $time, name, exp, act);
            err_cnt++;
        end
    endtask

    task automatic check_byte(input string name, input logic [BYTE_W-1:0] exp,
                              input logic [BYTE_W-1:0] act);
        if (act !== exp) begin
            $display("FAIL %0t %s expected %h actual %h", $time, name, exp, act);
            err_cnt++;
        end
    endtask

    task automatic check_req(input string name, input xm_vram_req_t exp,
                             input xm_vram_req_t act);
        if (act !== exp) begin
            $display("FAIL %0t %s expected %s actual %s",
                     $time, name, req_text(exp), req_text(act));
            err_cnt++;
        end
    endtask

    task automatic bus_write_byte(input xm_reg_e r, input logic s, input logic [BYTE_W-1:0] d);
        @(posedge clk);
        bus_wr_i      <= 1'b1;
        bus_reg_num_i <= r;
        bus_bytesel_i <= s;
        bus_data_i    <= d;
        @(posedge clk);
        bus_wr_i      <= 1'b0;
    endtask

    task automatic bus_write_word(input xm_reg_e r, input logic [WORD_W-1:0] w);
        bus_write_byte(r, 1'b0, w[WORD_W-1:BYTE_W]);    // even byte is the high byte
        bus_write_byte(r, 1'b1, w[BYTE_W-1:0]);
        @(posedge clk);
    endtask

    task automatic bus_read_byte(input xm_reg_e r, input logic s, output logic [BYTE_W-1:0] d);
        @(posedge clk);
        bus_rd_i      <= 1'b1;
        bus_reg_num_i <= r;
        bus_bytesel_i <= s;
        @(posedge clk);
        d = bus_data_o;                         // settled since last edge
        bus_rd_i      <= 1'b0;
    endtask

    task automatic read_reg_word(input xm_reg_e r, output logic [WORD_W-1:0] w);
        logic [BYTE_W-1:0] hi;
        logic [BYTE_W-1:0] lo;
        bus_read_byte(r, 1'b0, hi);
        bus_read_byte(r, 1'b1, lo);
        w = {hi, lo};
    endtask

    // waits for the next acceptance, then lets captures settle
    task automatic wait_accept(input int start_cnt);
        int n;
        n = 0;
        while (accept_cnt == start_cnt && n < ACC_LIMIT) begin
            @(posedge clk);
            n++;
        end
        if (accept_cnt == start_cnt) begin
            $display("%0t: VRAM request was never accepted", $time);
            err_cnt++;
        end
        repeat (2) @(posedge clk);
    endtask

    task automatic finish_test(input string name, input int err_before);
        tests_run++;
        if (err_cnt > err_before) begin
            tests_failed++;
            $display("%s: %0d errors", name, err_cnt - err_before);
        end else begin
            $display("%s: ok", name);
        end
    endtask

    task automatic test_readback();
        int e0;
        int snap;
        logic [WORD_W-1:0] w;
        logic [WORD_W-1:0] v;
        logic [BYTE_W-1:0] b;
        e0 = err_cnt;
        for (int r = 0; r < 16; r++) begin
            if (xm_reg_e'(r) == DATA || xm_reg_e'(r) == DATA_2) begin
                bus_read_byte(xm_reg_e'(r), 1'b0, b);   // even only, odd would prefetch
                check_byte($sformatf("bus_data_o reg %0d", r), 8'h00, b);
            end else if (xm_reg_e'(r) != TIMER) begin
                read_reg_word(xm_reg_e'(r), w);
                check_word($sformatf("bus_data_o reg %0d", r),
                           (xm_reg_e'(r) == SYS_CTRL) ? 16'h0F00 : 16'h0000, w);
            end
        end
        w = rand_word(16);
        snap = accept_cnt;
        bus_write_word(RD_ADDR, w);                     // rd increment still zero
        wait_accept(snap);
        read_reg_word(RD_ADDR, v);
        check_word("rd_addr", w, v);
        v = rand_word(16);
        bus_write_word(RD_INCR, v);
        read_reg_word(RD_INCR, w);
        check_word("rd_incr", v, w);
        v = rand_word(16);
        bus_write_word(WR_ADDR, v);
        read_reg_word(WR_ADDR, w);
        check_word("wr_addr", v, w);
        bus_write_byte(RD_INCR, 1'b0, 8'h5a);           // even byte lands on another reg
        bus_write_byte(WR_INCR, 1'b1, 8'h3c);
        read_reg_word(WR_INCR, w);
        check_word("wr_incr", 16'h003c, w);
        for (int r = 0; r < 16; r++) begin
            if (r < 2 || r > 9) begin               // dropped register numbers
                bus_write_word(xm_reg_e'(r), rand_word(16));
                read_reg_word(xm_reg_e'(r), w);
                check_word($sformatf("bus_data_o dropped reg %0d", r), 16'h0000, w);
            end
        end
        finish_test("readback", e0);
    endtask

    task automatic test_vram_write(input string name);
        int e0;
        int snap;
        logic [WORD_W-1:0] inc;
        logic [WORD_W-1:0] addr;
        logic [WORD_W-1:0] d;
        logic [WORD_W-1:0] w;
        e0 = err_cnt;
        inc = rand_word(16) | 16'h0001;                 // odd step, addresses stay distinct
        addr = rand_word(16);
        bus_write_word(WR_INCR, inc);
        bus_write_word(WR_ADDR, addr);
        for (int k = 0; k < 6; k++) begin
            d = rand_word(16);
            snap = accept_cnt;
            bus_write_word(k[0] ? DATA_2 : DATA, d);
            wait_accept(snap);
            check_req("vram_req_o", make_wr_req(4'hF, addr, d), last_req);
            check_word($sformatf("vram[%h]", addr), d, vram_mem[addr]);
            addr = addr + inc;
        end
        read_reg_word(WR_ADDR, w);
        check_word("wr_addr", addr, w);
        finish_test(name, e0);
    endtask

    task automatic test_vram_read(input string name);
        int e0;
        int snap;
        logic [WORD_W-1:0] inc;
        logic [WORD_W-1:0] cur;
        logic [WORD_W-1:0] exp;
        logic [WORD_W-1:0] w;
        logic [BYTE_W-1:0] b;
        e0 = err_cnt;
        inc = rand_word(16) | 16'h0001;
        cur = rand_word(16);
        bus_write_word(RD_INCR, inc);
        snap = accept_cnt;
        bus_write_word(RD_ADDR, cur);               // first read at start address
        wait_accept(snap);
        for (int k = 0; k < 6; k++) begin
            exp = vram_mem[cur];
            bus_read_byte(DATA, 1'b0, b);
            check_byte("bus_data_o DATA even", exp[WORD_W-1:BYTE_W], b);
            snap = accept_cnt;
            bus_read_byte(k[0] ? DATA_2 : DATA, 1'b1, b);   // odd read prefetches
            check_byte("bus_data_o DATA odd", exp[BYTE_W-1:0], b);
            wait_accept(snap);
            cur = cur + inc;
        end
        read_reg_word(RD_ADDR, w);
        check_word("rd_addr", cur + inc, w);        // one ahead of last prefetch
        finish_test(name, e0);
    endtask

    task automatic test_write_mask();
        int e0;
        int snap;
        logic [WORD_W-1:0] addr;
        logic [WORD_W-1:0] d;
        logic [WORD_W-1:0] old_w;
        logic [WORD_W-1:0] m16;
        logic [BYTE_W-1:0] b;
        e0 = err_cnt;
        addr = rand_word(16);
        bus_write_word(WR_INCR, 16'h0001);
        bus_write_word(WR_ADDR, addr);
        for (int k = 0; k < 4; k++) begin
            m16 = rand_word(MASK_W);
            bus_write_word(SYS_CTRL, {m16[MASK_W-1:0], 4'h0, 8'h00});
            bus_read_byte(SYS_CTRL, 1'b0, b);
            check_byte("bus_data_o SYS_CTRL", {4'h0, m16[MASK_W-1:0]}, b);
            d = rand_word(16);
            old_w = vram_mem[addr];
            snap = accept_cnt;
            bus_write_word(DATA, d);
            wait_accept(snap);
            check_req("vram_req_o", make_wr_req(m16[MASK_W-1:0], addr, d), last_req);
            check_word($sformatf("vram[%h]", addr),
                       mask_merge(old_w, d, m16[MASK_W-1:0]), vram_mem[addr]);
            addr = addr + 16'h0001;
        end
        bus_write_word(SYS_CTRL, 16'hF000);         // all nibbles again
        finish_test("write mask", e0);
    endtask

    task automatic test_timer(input int m);
        int e0;
        logic [BYTE_W-1:0] t0;
        logic [BYTE_W-1:0] t1;
        logic [BYTE_W-1:0] diff;
        int lo;
        e0 = err_cnt;
        lo = m / (TIMER_DIV + 1);
        bus_read_byte(TIMER, 1'b1, t0);
        repeat (m - 2) @(posedge clk);              // samples land m clocks apart
        bus_read_byte(TIMER, 1'b1, t1);
        diff = t1 - t0;
        if (diff != BYTE_W'(lo) && diff != BYTE_W'(lo + 1)) begin
            $display("FAIL %0t timer delta expected %0d or %0d actual %0d",
                     $time, lo, lo + 1, diff);
            err_cnt++;
        end
        finish_test($sformatf("timer over %0d clocks", m), e0);
    endtask

    initial begin
        #(2 * TEST_CYCLES * 2 * CLK_HALF);
        $display("watchdog: run did not finish in time");
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        reset_i       = 1'b1;
        bus_wr_i      = 1'b0;
        bus_rd_i      = 1'b0;
        bus_reg_num_i = XR_ADDR;
        bus_bytesel_i = 1'b0;
        bus_data_i    = '0;
        vgen_sel_i    = 1'b0;
        vram_data_i   = '0;
        for (int a = 0; a < 65536; a++) begin
            vram_mem[a] = fill_pattern(16'(a));
        end
        repeat (10) @(posedge clk);
        reset_i <= 1'b0;
        @(posedge clk);

        test_readback();
        test_vram_write("vram write");
        test_vram_read("vram read");
        test_write_mask();
        arb_on <= 1'b1;
        test_vram_write("arbitration write");
        test_vram_read("arbitration read");
        arb_on <= 1'b0;
        test_timer(200);
        test_timer(57);

        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, err_cnt);
        if (err_cnt == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* flist.f */
xm_pkg.sv
xm_byte_pair.sv
xm_vram_port.sv
xm_tick_timer.sv
xm_regs_top.sv
xm_regs_asserts.sv
tb_xm_regs.sv

/* run_sim.sh */
#!/bin/bash
# build and run the register block testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    -f flist.f \
    --top-module tb_xm_regs \
    -o sim_xm_regs > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "build failed, see build.log"
    exit 1
fi

./obj_dir/sim_xm_regs > sim.log 2>&1
sim_status=$?
cat sim.log

if grep -q "TEST FAILED" sim.log; then
    echo "simulation failed"
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "simulator exited with status $sim_status"
    exit 1
fi
if ! grep -q "TEST PASSED" sim.log; then
    echo "no pass line in sim.log"
    exit 1
fi
exit 0
